// File: spuVoice.f
logic/spuPkg.sv
logic/tapBus.sv
logic/sampleHistory.sv
logic/splineWeightGen.sv
logic/gaussInterpolator.sv
logic/voiceSequencer.sv
logic/spuVoiceTop.sv
tests/spuVoiceTb.sv

// File: Makefile
# Verilator build and run for the voice stage testbench

SRCS := $(shell grep -v '^+' spuVoice.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VspuVoiceTb: spuVoice.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module spuVoiceTb -f spuVoice.f

# Log decides the result, a missing pass line also counts as failure
run: obj_dir/VspuVoiceTb tests/spuVoiceStim.txt
	./obj_dir/VspuVoiceTb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
		echo "simulation reported a failure, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: tests/spuVoiceStim.txt
// Columns, all hex: test, push, channel, frac, sample, expected sample
// Expected values use floor(P/3072) weights and per-tap arithmetic shift by 15
01 0 00 00 0000 0000
02 0 05 80 0000 0000
03 0 11 ff 0000 0000
04 0 17 40 0000 0000
05 1 03 00 03e8 0000
06 1 03 80 07d0 0208
07 1 03 ff 0bb8 07cb
08 1 03 40 0fa0 08c8
09 0 03 00 0000 07ce
0a 0 03 80 0000 09c2
0b 0 03 ff 0000 0bb2
0c 1 04 00 7fff 0000
0d 0 03 80 0000 09c2
0e 0 00 40 0000 0000
0f 1 0a ff 8000 eaeb
10 1 0a 80 7fff c554
11 1 0a 00 ffff bfff
12 1 0a 40 cfc7 4532
13 0 0a 40 0000 4532
14 0 0a ff 0000 0da1
15 0 0a 00 0000 3ffe
16 0 0a 80 0000 39a8
17 0 03 00 0000 07ce
18 0 04 80 0000 02a9
19 0 05 ff 0000 0000
1a 1 04 40 7fff 28a8
1b 1 04 ff 7fff 7ffb
1c 1 04 80 7fff 7ffa
1d 0 17 80 0000 0000

// File: tests/spuVoiceTb.sv
`timescale 1ns/100ps
`default_nettype none

module spuVoiceTb;

	// Six hex words per command in the stim file
	localparam int MaxLines = 64;
	localparam int Fields = 6;
	localparam logic [15:0] EndMark = 16'hFFFF;

	// Edges from raising req to ack high
	localparam int AckLatency = 7;

	// ********************
	// DUT signals
	// ********************
	logic              clk;
	logic              rst;
	logic              cmdReq;
	spuPkg::channel_t  cmdChannel;
	spuPkg::frac_t     cmdFrac;
	logic              cmdPush;
	spuPkg::sample_t   cmdSample;
	logic              cmdAck;
	spuPkg::sample_t   outSample;
	spuPkg::channel_t  outChannel;

	// Stim words with the test number field doubling as end marker
	logic [15:0]       stimMem [MaxLines * Fields];
	int                numLines;

	// Run limit set once the stim is loaded
	int                cycleCount = 0;
	int                cycleLimit = 100000;

	spuVoiceTop #(
		.NumChannels  (spuPkg::DefaultChannels)
	) i_spuVoiceTop (
		.i_clk        (clk),
		.i_rst        (rst),
		.i_cmdReq     (cmdReq),
		.i_cmdChannel (cmdChannel),
		.i_cmdFrac    (cmdFrac),
		.i_cmdPush    (cmdPush),
		.i_cmdSample  (cmdSample),
		.o_cmdAck     (cmdAck),
		.o_outSample  (outSample),
		.o_outChannel (outChannel)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ********************
	// Failure helpers
	// ********************
	task automatic abortRun();
		$display("test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkValue(input string name, input string what,
		input logic [15:0] expected, input logic [15:0] actual);
		assert (expected == actual)
		else begin
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
			abortRun();
		end
	endtask

	// Hard stop if the handshake ever hangs
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		assert (cycleCount < cycleLimit)
		else begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
			abortRun();
		end
	end

	// ********************
	// One four-phase command
	// ********************
	task automatic runCommand(input int idx);
		logic [15:0] testNum;
		logic [15:0] expected;
		logic [15:0] expChannel;
		string       name;
		int          waitCycles;
		int          hold;
		testNum    = stimMem[idx * Fields];
		expected   = stimMem[idx * Fields + 5];
		expChannel = {11'd0, stimMem[idx * Fields + 2][4:0]};
		name       = $sformatf("test %0d", testNum);
		// Fields go out together with req while ack is low
		cmdPush    = stimMem[idx * Fields + 1][0];
		cmdChannel = stimMem[idx * Fields + 2][4:0];
		cmdFrac    = stimMem[idx * Fields + 3][7:0];
		cmdSample  = stimMem[idx * Fields + 4];
		cmdReq     = 1'b1;
		// Count edges until ack within a bound
		waitCycles = 0;
		do begin
			@(posedge clk);
			#1;
			waitCycles++;
		end while (!cmdAck && waitCycles < AckLatency + 4);
		assert (cmdAck)
		else begin
			$display("%s: ack never rose after req was raised", name);
			abortRun();
		end
		checkValue(name, "ack latency", 16'(AckLatency), 16'(waitCycles));
		checkValue(name, "channel", expChannel, {11'd0, outChannel});
		checkValue(name, "sample", expected, outSample);
		// Stall with req high and expect a steady answer
		hold = testNum % 4;
		repeat (hold) begin
			@(posedge clk);
			#1;
			assert (cmdAck)
			else begin
				$display("%s: ack dropped while req was still high", name);
				abortRun();
			end
			checkValue(name, "held channel", expChannel, {11'd0, outChannel});
			checkValue(name, "held sample", expected, outSample);
		end
		// Ack drops one edge after req falls
		cmdReq = 1'b0;
		@(posedge clk);
		#1;
		assert (!cmdAck)
		else begin
			$display("%s: ack still high one cycle after req fell", name);
			abortRun();
		end
	endtask

	// ********************
	// Main sequence
	// ********************
	initial begin
		rst        = 1'b1;
		cmdReq     = 1'b0;
		cmdChannel = '0;
		cmdFrac    = '0;
		cmdPush    = 1'b0;
		cmdSample  = '0;
		for (int i = 0; i < MaxLines * Fields; i++) begin
			stimMem[i] = EndMark;
		end
		$readmemh("tests/spuVoiceStim.txt", stimMem);
		numLines = 0;
		while (numLines < MaxLines && stimMem[numLines * Fields] != EndMark) begin
			numLines++;
		end
		assert (numLines > 0)
		else begin
			$display("The stim file held no commands");
			abortRun();
		end
		// Room for latency, stalls and release per command
		cycleLimit = 20 * numLines + 10;
		// Three edges of reset
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int line = 0; line < numLines; line++) begin
			runCommand(line);
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/spuVoiceTop.sv
`timescale 1ns/100ps
`default_nettype none

module spuVoiceTop #(
	parameter int NumChannels = spuPkg::DefaultChannels
) (
	input  logic                i_clk,
	input  logic                i_rst,

	// Command side
	input  logic                i_cmdReq,
	input  spuPkg::channel_t    i_cmdChannel,
	input  spuPkg::frac_t       i_cmdFrac,
	input  logic                i_cmdPush,
	input  spuPkg::sample_t     i_cmdSample,
	output logic                o_cmdAck,

	// Interpolated answer
	output spuPkg::sample_t     o_outSample,
	output spuPkg::channel_t    o_outChannel
);

	// ********************
	// Internal nets
	// ********************

	// History push and lookup
	logic              wrEn;
	spuPkg::channel_t  wrChannel;
	spuPkg::sample_t   wrSample;
	spuPkg::channel_t  rdChannel;
	spuPkg::history_t  rdTaps;

	// Interpolator back to sequencer
	spuPkg::sample_t   resSample;
	spuPkg::channel_t  resChannel;
	logic              resValid;

	// Sequencer to interpolator job
	tapBus jobBus ();

	// Per-voice sample store
	sampleHistory #(
		.NumChannels (NumChannels)
	) u_history (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_wrEn      (wrEn),
		.i_wrChannel (wrChannel),
		.i_wrSample  (wrSample),
		.i_rdChannel (rdChannel),
		.o_rdTaps    (rdTaps)
	);

	// Handshake and control
	voiceSequencer #(
		.NumChannels (NumChannels)
	) u_sequencer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmdReq     (i_cmdReq),
		.i_cmdChannel (i_cmdChannel),
		.i_cmdFrac    (i_cmdFrac),
		.i_cmdPush    (i_cmdPush),
		.i_cmdSample  (i_cmdSample),
		.o_cmdAck     (o_cmdAck),
		.o_wrEn       (wrEn),
		.o_wrChannel  (wrChannel),
		.o_wrSample   (wrSample),
		.o_rdChannel  (rdChannel),
		.i_rdTaps     (rdTaps),
		.job          (jobBus.sequencer),
		.i_resSample  (resSample),
		.i_resChannel (resChannel),
		.i_resValid   (resValid),
		.o_outSample  (o_outSample),
		.o_outChannel (o_outChannel)
	);

	// Four-tap MAC
	gaussInterpolator u_interp (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.job       (jobBus.interpolator),
		.o_sample  (resSample),
		.o_channel (resChannel),
		.o_valid   (resValid)
	);

endmodule

`default_nettype wire

// File: logic/voiceSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module voiceSequencer #(
	parameter int NumChannels = spuPkg::DefaultChannels
) (
	input  logic                i_clk,
	input  logic                i_rst,

	// Four-phase command port
	input  logic                i_cmdReq,
	input  spuPkg::channel_t    i_cmdChannel,
	input  spuPkg::frac_t       i_cmdFrac,
	input  logic                i_cmdPush,
	input  spuPkg::sample_t     i_cmdSample,
	output logic                o_cmdAck,

	// History push
	output logic                o_wrEn,
	output spuPkg::channel_t    o_wrChannel,
	output spuPkg::sample_t     o_wrSample,

	// History lookup
	output spuPkg::channel_t    o_rdChannel,
	input  spuPkg::history_t    i_rdTaps,

	// Job launch
	tapBus.sequencer            job,

	// Interpolator result
	input  spuPkg::sample_t     i_resSample,
	input  spuPkg::channel_t    i_resChannel,
	input  logic                i_resValid,

	// Answer to the controller
	output spuPkg::sample_t     o_outSample,
	output spuPkg::channel_t    o_outChannel
);

	// ********************
	// Handshake FSM
	// ********************
	typedef enum logic [1:0] {
		Idle   = 2'd0,
		Launch = 2'd1,
		Wait   = 2'd2,
		Ack    = 2'd3
	} state_t;

	state_t            state;
	state_t            stateNext;

	// Latched command
	spuPkg::channel_t  cmdChannel;
	spuPkg::frac_t     cmdFrac;

	// New command only from Idle, where ack is already low
	logic              cmdTake;

	assign cmdTake = (state == Idle) && i_cmdReq;

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (i_cmdReq) begin
					stateNext = Launch;
				end
			end
			// History already holds the push from the last cycle
			Launch: begin
				stateNext = Wait;
			end
			Wait: begin
				if (i_resValid) begin
					stateNext = Ack;
				end
			end
			// Hold answer until the controller lets go
			Ack: begin
				if (!i_cmdReq) begin
					stateNext = Idle;
				end
			end
			default: begin
				stateNext = Idle;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= Idle;
		end else begin
			state <= stateNext;
		end
	end

	// Command fields captured when the command is taken
	always_ff @(posedge i_clk) begin
		if (cmdTake) begin
			cmdChannel <= i_cmdChannel;
			cmdFrac    <= i_cmdFrac;
		end
	end

	// ********************
	// History and job
	// ********************

	// Push goes in the same cycle the command is taken
	// Pushes to voices that do not exist are dropped
	assign o_wrEn      = cmdTake && i_cmdPush && (i_cmdChannel < NumChannels);
	assign o_wrChannel = i_cmdChannel;
	assign o_wrSample  = i_cmdSample;

	assign o_rdChannel = cmdChannel;

	assign job.go      = (state == Launch);
	assign job.channel = cmdChannel;
	assign job.frac    = cmdFrac;
	assign job.taps    = i_rdTaps;

	// ********************
	// Result hold
	// ********************
	always_ff @(posedge i_clk) begin
		if ((state == Wait) && i_resValid) begin
			o_outSample  <= i_resSample;
			o_outChannel <= i_resChannel;
		end
	end

	assign o_cmdAck = (state == Ack);

	// Controller keeps req up until it sees ack
	assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_cmdAck) |-> $past(i_cmdReq))
		else $error("voiceSequencer: ack rose while req was low");

endmodule

`default_nettype wire

// File: logic/gaussInterpolator.sv
`timescale 1ns/100ps
`default_nettype none

module gaussInterpolator (
	input  logic                i_clk,
	input  logic                i_rst,

	// Job from the sequencer
	tapBus.interpolator         job,

	// Result, held until the next job
	output spuPkg::sample_t     o_sample,
	output spuPkg::channel_t    o_channel,
	output logic                o_valid
);

	// Counter value once all four taps are in
	localparam logic [2:0] StepDone = 3'd5;

	// ********************
	// Job capture
	// ********************
	spuPkg::history_t  tapsReg;
	spuPkg::channel_t  chanReg;
	spuPkg::frac_t     fracReg;

	// 0 idle after reset, 1 to 4 accumulating, 5 done
	logic [2:0]        stepCnt;

	// Weight request, selector and fraction
	spuPkg::tapSel_t   tapSel;
	spuPkg::tapSel_t   tapDly;
	spuPkg::frac_t     weightFrac;
	spuPkg::weight_t   weight;

	// MAC datapath
	spuPkg::sample_t   curSample;
	logic signed [32:0] product;
	logic signed [32:0] scaled;
	logic signed [17:0] acc;
	logic              accumulating;

	// New tap is requested during go itself so its weight is ready next cycle
	assign tapSel     = job.go ? spuPkg::New : spuPkg::tapSel_t'(stepCnt[1:0]);
	assign weightFrac = job.go ? job.frac : fracReg;

	// Weight comes back one cycle after the request
	splineWeightGen u_weightGen (
		.i_clk    (i_clk),
		.i_tap    (tapSel),
		.i_frac   (weightFrac),
		.o_weight (weight)
	);

	// ********************
	// Sample and weight alignment
	// ********************

	// Selector follows the weight ROM by one cycle
	always_ff @(posedge i_clk) begin
		tapDly <= tapSel;
	end

	always_comb begin
		case (tapDly)
			spuPkg::New:    curSample = tapsReg.newest;
			spuPkg::Old:    curSample = tapsReg.old;
			spuPkg::Older:  curSample = tapsReg.older;
			default:        curSample = tapsReg.oldest;
		endcase
	end

	// Weight is positive, so zero-extend before the signed multiply
	assign product = curSample * $signed({1'b0, weight});
	assign scaled  = product >>> 15;

	assign accumulating = (stepCnt != 3'd0) && (stepCnt != StepDone);

	// ********************
	// Step counter
	// ********************
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			stepCnt <= 3'd0;
		end else if (job.go) begin
			stepCnt <= 3'd1;
		end else if (accumulating) begin
			stepCnt <= stepCnt + 3'd1;
		end
	end

	// Capture on go, then sum four products, no clamping
	always_ff @(posedge i_clk) begin
		if (job.go) begin
			tapsReg <= job.taps;
			chanReg <= job.channel;
			fracReg <= job.frac;
			acc     <= '0;
		end else if (accumulating) begin
			acc <= acc + scaled[17:0];
		end
	end

	assign o_sample  = acc[15:0];
	assign o_channel = chanReg;
	assign o_valid   = (stepCnt == StepDone);

	// A new job must not cut into one still summing
	assert property (@(posedge i_clk) disable iff (i_rst)
		job.go |-> !accumulating)
		else $error("gaussInterpolator: go while step %0d still accumulating", stepCnt);

endmodule

`default_nettype wire

// File: logic/splineWeightGen.sv
`timescale 1ns/100ps
`default_nettype none

module splineWeightGen (
	input  logic              i_clk,

	// Which tap and where between samples
	input  spuPkg::tapSel_t   i_tap,
	input  spuPkg::frac_t     i_frac,

	// Weight for the request of the previous cycle
	output spuPkg::weight_t   o_weight
);

	// ********************
	// Powers of f
	// ********************

	// All terms scaled by 256^3, so 32 bits unsigned is enough
	logic [31:0] fVal;
	logic [31:0] gVal;
	logic [31:0] fSq;
	logic [31:0] fCube;
	logic [31:0] gCube;

	// Polynomial for the selected tap
	logic [31:0] poly;

	// Complement distance, 256 - f
	assign fVal  = {24'd0, i_frac};
	assign gVal  = 32'd256 - fVal;
	assign fSq   = fVal * fVal;
	assign fCube = fSq * fVal;
	assign gCube = gVal * gVal * gVal;

	// ********************
	// Cubic B-spline terms
	// ********************
	always_comb begin
		case (i_tap)
			// Rises from zero as f grows
			spuPkg::New: begin
				poly = fCube;
			end
			// Peak side nearest the new sample
			spuPkg::Old: begin
				poly = 32'd16777216 + 32'd196608 * fVal + 32'd768 * fSq - 32'd3 * fCube;
			end
			// Peak side nearest the oldest sample
			spuPkg::Older: begin
				poly = 32'd67108864 + 32'd3 * fCube - 32'd1536 * fSq;
			end
			// Mirror of the New term
			spuPkg::Oldest: begin
				poly = gCube;
			end
			default: begin
				poly = '0;
			end
		endcase
	end

	// ********************
	// Scale to Q15 and register
	// ********************

	// Four terms sum to 3 * 2^25, divide by 3072 to land on 2^15
	// Integer divide gives the floor, terms never go negative
	always_ff @(posedge i_clk) begin
		o_weight <= spuPkg::weight_t'(poly / 32'd3072);
	end

endmodule

`default_nettype wire

// File: logic/sampleHistory.sv
`timescale 1ns/100ps
`default_nettype none

module sampleHistory #(
	parameter int NumChannels = spuPkg::DefaultChannels
) (
	input  logic               i_clk,
	input  logic               i_rst,

	// Push port
	input  logic               i_wrEn,
	input  spuPkg::channel_t   i_wrChannel,
	input  spuPkg::sample_t    i_wrSample,

	// Lookup port
	input  spuPkg::channel_t   i_rdChannel,
	output spuPkg::history_t   o_rdTaps
);

	// ********************
	// Storage
	// ********************

	// One four-deep history per voice
	spuPkg::history_t histMem [NumChannels];

	// Current contents of the channel being pushed
	spuPkg::history_t wrCur;

	// Range checks, channel field is wider than the voice count
	logic wrInRange;
	logic rdInRange;

	assign wrInRange = (i_wrChannel < NumChannels);
	assign rdInRange = (i_rdChannel < NumChannels);

	assign wrCur = wrInRange ? histMem[i_wrChannel] : '0;

	// ********************
	// Shift on push
	// ********************
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// Every voice starts silent
			for (int i = 0; i < NumChannels; i++) begin
				histMem[i] <= '0;
			end
		end else if (i_wrEn && wrInRange) begin
			// Everything moves one slot older
			histMem[i_wrChannel].oldest <= wrCur.older;
			histMem[i_wrChannel].older  <= wrCur.old;
			histMem[i_wrChannel].old    <= wrCur.newest;
			// Fresh sample lands in newest
			histMem[i_wrChannel].newest <= i_wrSample;
		end
	end

	// ********************
	// Combinational read
	// ********************

	// Out of range voices read as silence
	assign o_rdTaps = rdInRange ? histMem[i_rdChannel] : '0;

	// Sequencer must never push to a voice that does not exist
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_wrEn |-> (i_wrChannel < NumChannels))
		else $error("sampleHistory: push to channel %0d beyond %0d voices",
			i_wrChannel, NumChannels);

endmodule

`default_nettype wire

// File: logic/tapBus.sv
`timescale 1ns/100ps
`default_nettype none

// ********************
// One interpolation job
// ********************
interface tapBus;

	// Single-cycle start strobe
	logic              go;

	// Job payload, valid while go is high
	spuPkg::channel_t  channel;
	spuPkg::frac_t     frac;
	spuPkg::history_t  taps;

	// Launch side
	modport sequencer (
		output go,
		output channel,
		output frac,
		output taps
	);

	// MAC side
	modport interpolator (
		input  go,
		input  channel,
		input  frac,
		input  taps
	);

endinterface

`default_nettype wire

// File: logic/spuPkg.sv
`default_nettype none

package spuPkg;

	// ********************
	// Sample path types
	// ********************

	// Decoded audio sample
	typedef logic signed [15:0] sample_t;

	// Voice channel number
	typedef logic [4:0] channel_t;

	// Position between old and new sample, 0 to 255
	typedef logic [7:0] frac_t;

	// Q15 tap weight, always positive
	typedef logic [15:0] weight_t;

	// Tap order as stepped by the interpolator
	typedef enum logic [1:0] {
		New    = 2'd0,
		Old    = 2'd1,
		Older  = 2'd2,
		Oldest = 2'd3
	} tapSel_t;

	// Four most recent samples of one channel
	typedef struct packed {
		sample_t newest;
		sample_t old;
		sample_t older;
		sample_t oldest;
	} history_t;

	// Voice count used when the top level does not override it
	localparam int DefaultChannels = 24;

endpackage

`default_nettype wire
